// ==== logic/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	localparam int ISSUE_NUM         = 2;
	localparam int DCACHE_PIPE_DEPTH = 2;
	localparam int QUEUE_DEPTH       = 8;
	localparam int QPTR_W            = $clog2(QUEUE_DEPTH);
	localparam int ISSUE_CNT_W       = $clog2(ISSUE_NUM + 1);

	// primary opcodes
	localparam logic [5:0] OPC_SPECIAL  = 6'b000000;
	localparam logic [5:0] OPC_REGIMM   = 6'b000001;
	localparam logic [5:0] OPC_J        = 6'b000010;
	localparam logic [5:0] OPC_JAL      = 6'b000011;
	localparam logic [5:0] OPC_BEQ      = 6'b000100;
	localparam logic [5:0] OPC_BNE      = 6'b000101;
	localparam logic [5:0] OPC_BLEZ     = 6'b000110;
	localparam logic [5:0] OPC_BGTZ     = 6'b000111;
	localparam logic [5:0] OPC_COP0     = 6'b010000;
	localparam logic [5:0] OPC_SPECIAL2 = 6'b011100;
	localparam logic [5:0] OPC_LL       = 6'b110000;
	localparam logic [5:0] OPC_SC       = 6'b111000;

	// SPECIAL function codes
	localparam logic [5:0] FN_JR    = 6'b001000;
	localparam logic [5:0] FN_JALR  = 6'b001001;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MTHI  = 6'b010001;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MTLO  = 6'b010011;
	localparam logic [5:0] FN_MULT  = 6'b011000;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_DIV   = 6'b011010;
	localparam logic [5:0] FN_DIVU  = 6'b011011;
	localparam logic [5:0] FN_ERET  = 6'b011000;

	// COP0 rs field
	localparam logic [4:0] COP0_MF = 5'b00000;
	localparam logic [4:0] COP0_MT = 5'b00100;

	// sll r0, r0, 1
	localparam logic [31:0] SSNOP_WORD = 32'h0000_0040;

	typedef enum logic [3:0] {
		OP_NOP, OP_ALU, OP_LOAD, OP_STORE, OP_SC, OP_BRANCH, OP_MULT,
		OP_DIV, OP_DIVU, OP_HILO, OP_MFC0, OP_MTC0, OP_ERET
	} op_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_word_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		instr_word_t instr;
	} fetch_entry_t;

	typedef struct packed {
		op_t         op;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		// zero when nothing is written
		logic [4:0]  rd;
		logic        is_load;
		logic        is_store;
		logic        is_controlflow;
		logic        is_hilo;
		logic        is_priv;
		logic        is_nonrw_priv;
		logic [31:0] pc;
		logic [31:0] instr;
	} decoded_instr_t;

endpackage

// two oldest queue entries, and how many of them leave
interface head_if;
	issue_pkg::fetch_entry_t [issue_pkg::ISSUE_NUM-1:0] entry;
	logic [issue_pkg::ISSUE_CNT_W-1:0]                 pop_num;

	modport queue (output entry, input pop_num);
	modport issue (input entry, output pop_num);
endinterface

// pipeline contents seen by the issue logic
interface stage_if;
	issue_pkg::decoded_instr_t [issue_pkg::ISSUE_NUM-1:0] ex_instr;
	issue_pkg::decoded_instr_t [issue_pkg::DCACHE_PIPE_DEPTH-1:0][issue_pkg::ISSUE_NUM-1:0]
		dcache_instr;
	issue_pkg::decoded_instr_t [issue_pkg::ISSUE_NUM-1:0] issue_instr;
	logic [issue_pkg::ISSUE_CNT_W-1:0]                   issue_num;

	modport tracker (output ex_instr, output dcache_instr, input issue_instr, input issue_num);
	modport issue (input ex_instr, input dcache_instr, output issue_instr, output issue_num);
endinterface

`default_nettype wire

// ==== logic/fetch_queue.sv ====
`default_nettype none

module fetch_queue (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  fetch_valid,
	input  logic [31:0]                           fetch_pc,
	input  logic [31:0]                           fetch_instr,
	head_if.queue                                 head,
	output logic [issue_pkg::ISSUE_CNT_W-1:0]     credit_return
);

	issue_pkg::fetch_entry_t mem [issue_pkg::QUEUE_DEPTH];
	issue_pkg::fetch_entry_t wr_entry;
	issue_pkg::fetch_entry_t [issue_pkg::ISSUE_NUM-1:0] rd_entry;

	logic [issue_pkg::QPTR_W-1:0] wr_ptr;
	logic [issue_pkg::QPTR_W-1:0] rd_ptr;
	logic [issue_pkg::QPTR_W:0]   count;
	logic [issue_pkg::QPTR_W:0]   push_num;
	logic [issue_pkg::QPTR_W:0]   pop_ext;

	always_comb begin
		wr_entry       = '0;
		wr_entry.valid = 1'b1;
		wr_entry.pc    = fetch_pc;
		wr_entry.instr = fetch_instr;
	end

	// the count decides which entries are live
	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	assign push_num = {{issue_pkg::QPTR_W{1'b0}}, fetch_valid};
	assign pop_ext  = (issue_pkg::QPTR_W + 1)'(head.pop_num);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (fetch_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// pointer wraps since the depth is a power of two
			rd_ptr <= rd_ptr + issue_pkg::QPTR_W'(head.pop_num);
			count  <= count + push_num - pop_ext;
		end
	end

	// one credit back per popped entry a cycle after the pop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_return <= '0;
		end else begin
			credit_return <= head.pop_num;
		end
	end

	always_comb begin
		for (int i = 0; i < issue_pkg::ISSUE_NUM; i++) begin
			rd_entry[i]       = mem[rd_ptr + issue_pkg::QPTR_W'(i)];
			rd_entry[i].valid = rd_entry[i].valid & (count > i);
		end
	end

	assign head.entry = rd_entry;

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
	input  issue_pkg::fetch_entry_t   entry,
	output issue_pkg::decoded_instr_t decoded
);

	issue_pkg::r_fmt_t rf;
	issue_pkg::i_fmt_t itf;

	assign rf  = entry.instr.r;
	assign itf = entry.instr.i;

	always_comb begin
		decoded       = '0;
		decoded.pc    = entry.pc;
		decoded.instr = entry.instr;
		if (entry.valid) begin
			case (itf.opcode) inside
				issue_pkg::OPC_SPECIAL: begin
					decoded.rs1 = rf.rs;
					decoded.rs2 = rf.rt;
					case (rf.funct)
						issue_pkg::FN_JR: begin
							decoded.op             = issue_pkg::OP_BRANCH;
							decoded.rs2            = '0;
							decoded.is_controlflow = 1'b1;
						end
						issue_pkg::FN_JALR: begin
							decoded.op             = issue_pkg::OP_BRANCH;
							decoded.rs2            = '0;
							decoded.rd             = rf.rd;
							decoded.is_controlflow = 1'b1;
						end
						issue_pkg::FN_MFHI, issue_pkg::FN_MFLO: begin
							decoded.op      = issue_pkg::OP_HILO;
							decoded.rs1     = '0;
							decoded.rs2     = '0;
							decoded.rd      = rf.rd;
							decoded.is_hilo = 1'b1;
						end
						issue_pkg::FN_MTHI, issue_pkg::FN_MTLO: begin
							decoded.op      = issue_pkg::OP_HILO;
							decoded.rs2     = '0;
							decoded.is_hilo = 1'b1;
						end
						issue_pkg::FN_MULT, issue_pkg::FN_MULTU: begin
							decoded.op      = issue_pkg::OP_MULT;
							decoded.is_hilo = 1'b1;
						end
						issue_pkg::FN_DIV: begin
							decoded.op      = issue_pkg::OP_DIV;
							decoded.is_hilo = 1'b1;
						end
						issue_pkg::FN_DIVU: begin
							decoded.op      = issue_pkg::OP_DIVU;
							decoded.is_hilo = 1'b1;
						end
						default: begin
							// all-zero word is the canonical nop
							decoded.op = (entry.instr == '0) ? issue_pkg::OP_NOP
							                                 : issue_pkg::OP_ALU;
							decoded.rd = rf.rd;
						end
					endcase
				end
				issue_pkg::OPC_SPECIAL2: begin
					decoded.rs1 = rf.rs;
					decoded.rs2 = rf.rt;
					// MADD/MADDU/MSUB/MSUBU accumulate into HI/LO, the rest write rd
					if (rf.funct[5:3] == 3'b000 && !rf.funct[1]) begin
						decoded.op      = issue_pkg::OP_MULT;
						decoded.is_hilo = 1'b1;
					end else begin
						decoded.op = issue_pkg::OP_ALU;
						decoded.rd = rf.rd;
					end
				end
				issue_pkg::OPC_REGIMM: begin
					decoded.op             = issue_pkg::OP_BRANCH;
					decoded.rs1            = itf.rs;
					decoded.is_controlflow = 1'b1;
					// BLTZAL/BGEZAL link
					decoded.rd             = itf.rt[4] ? 5'd31 : 5'd0;
				end
				issue_pkg::OPC_J, issue_pkg::OPC_JAL: begin
					decoded.op             = issue_pkg::OP_BRANCH;
					decoded.is_controlflow = 1'b1;
					decoded.rd             = itf.opcode[0] ? 5'd31 : 5'd0;
				end
				issue_pkg::OPC_BEQ, issue_pkg::OPC_BNE,
				issue_pkg::OPC_BLEZ, issue_pkg::OPC_BGTZ: begin
					decoded.op             = issue_pkg::OP_BRANCH;
					decoded.rs1            = itf.rs;
					decoded.rs2            = itf.opcode[1] ? 5'd0 : itf.rt;
					decoded.is_controlflow = 1'b1;
				end
				6'b001???: begin
					decoded.op  = issue_pkg::OP_ALU;
					decoded.rs1 = itf.rs;
					decoded.rd  = itf.rt;
				end
				issue_pkg::OPC_COP0: begin
					if (rf.rs == issue_pkg::COP0_MF) begin
						decoded.op      = issue_pkg::OP_MFC0;
						decoded.rd      = rf.rt;
						decoded.is_priv = 1'b1;
					end else if (rf.rs == issue_pkg::COP0_MT) begin
						decoded.op      = issue_pkg::OP_MTC0;
						decoded.rs1     = rf.rt;
						decoded.is_priv = 1'b1;
					end else if (rf.rs[4] && rf.funct == issue_pkg::FN_ERET) begin
						decoded.op            = issue_pkg::OP_ERET;
						decoded.is_priv       = 1'b1;
						decoded.is_nonrw_priv = 1'b1;
					end
				end
				6'b100???, issue_pkg::OPC_LL: begin
					decoded.op      = issue_pkg::OP_LOAD;
					decoded.rs1     = itf.rs;
					decoded.rd      = itf.rt;
					decoded.is_load = 1'b1;
				end
				6'b101???: begin
					decoded.op       = issue_pkg::OP_STORE;
					decoded.rs1      = itf.rs;
					decoded.rs2      = itf.rt;
					decoded.is_store = 1'b1;
				end
				issue_pkg::OPC_SC: begin
					// SC also writes its success flag into rt
					decoded.op       = issue_pkg::OP_SC;
					decoded.rs1      = itf.rs;
					decoded.rs2      = itf.rt;
					decoded.rd       = itf.rt;
					decoded.is_store = 1'b1;
				end
				default: decoded.op = issue_pkg::OP_NOP;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/instr_issue.sv ====
`default_nettype none

// fixed at two issue slots
module instr_issue (
	input  issue_pkg::fetch_entry_t   entry0,
	input  issue_pkg::fetch_entry_t   entry1,
	input  issue_pkg::decoded_instr_t id0,
	input  issue_pkg::decoded_instr_t id1,
	stage_if.issue                    stage,
	head_if.issue                     head
);

	function automatic logic is_ssnop(input issue_pkg::fetch_entry_t e);
		return e.valid && e.instr == issue_pkg::SSNOP_WORD;
	endfunction

	// a load ahead in the pipe writes a register this one reads
	function automatic logic is_load_related(
		input issue_pkg::decoded_instr_t id,
		input issue_pkg::decoded_instr_t ex
	);
		return ex.is_load && ex.rd != '0 && (id.rs1 == ex.rd || id.rs2 == ex.rd);
	endfunction

	function automatic logic is_data_related(
		input issue_pkg::decoded_instr_t older,
		input issue_pkg::decoded_instr_t younger
	);
		return older.rd != '0 && (younger.rs1 == older.rd || younger.rs2 == older.rd);
	endfunction

	issue_pkg::decoded_instr_t [issue_pkg::ISSUE_NUM-1:0] id;
	issue_pkg::decoded_instr_t [issue_pkg::ISSUE_NUM-1:0] issue_instr;
	logic [issue_pkg::ISSUE_CNT_W-1:0] issue_num;

	logic [issue_pkg::ISSUE_NUM-1:0] instr_valid;
	logic [issue_pkg::ISSUE_NUM-1:0] load_related;
	logic [issue_pkg::ISSUE_NUM-1:0] mem_access;
	logic [issue_pkg::ISSUE_NUM-1:0] hilo_access;
	logic priv_executing;
	logic nonrw_priv_executing;
	logic delayslot_load_related;
	logic instr2_not_taken;
	logic stall_req;

	assign id[0]       = id0;
	assign id[1]       = id1;
	assign instr_valid = {entry1.valid, entry0.valid};

	for (genvar i = 0; i < issue_pkg::ISSUE_NUM; i++) begin : g_access
		assign mem_access[i]  = id[i].is_load | id[i].is_store;
		assign hilo_access[i] = id[i].is_hilo;
	end

	// load-use only against EX and the first D-cache stage
	always_comb begin
		load_related = '0;
		for (int i = 0; i < issue_pkg::ISSUE_NUM; i++) begin
			for (int j = 0; j < issue_pkg::ISSUE_NUM; j++) begin
				load_related[i] |= is_load_related(id[i], stage.ex_instr[j]);
				for (int k = 0; k < issue_pkg::DCACHE_PIPE_DEPTH - 1; k++) begin
					load_related[i] |= is_load_related(id[i], stage.dcache_instr[k][j]);
				end
			end
		end
		load_related &= instr_valid;
	end

	always_comb begin
		priv_executing       = 1'b0;
		nonrw_priv_executing = 1'b0;
		for (int i = 0; i < issue_pkg::ISSUE_NUM; i++) begin
			priv_executing       |= stage.ex_instr[i].is_priv;
			nonrw_priv_executing |= stage.ex_instr[i].is_nonrw_priv;
			for (int k = 0; k < issue_pkg::DCACHE_PIPE_DEPTH; k++) begin
				priv_executing       |= stage.dcache_instr[k][i].is_priv;
				nonrw_priv_executing |= stage.dcache_instr[k][i].is_nonrw_priv;
			end
		end
	end

	// a branch must not pair with its delay slot while a load is still in flight
	always_comb begin
		delayslot_load_related = id[0].is_load;
		for (int i = 0; i < issue_pkg::ISSUE_NUM; i++) begin
			delayslot_load_related |= stage.ex_instr[i].is_load;
			for (int k = 0; k < issue_pkg::DCACHE_PIPE_DEPTH - 1; k++) begin
				delayslot_load_related |= stage.dcache_instr[k][i].is_load;
			end
		end
		delayslot_load_related &= id[1].is_controlflow;
	end

	assign instr2_not_taken = ~instr_valid[1]
		|| is_data_related(id[0], id[1])
		|| (mem_access[0] & mem_access[1])
		|| (hilo_access[0] & hilo_access[1])
		|| delayslot_load_related
		|| is_ssnop(entry0) || is_ssnop(entry1)
		|| id[0].op == issue_pkg::OP_SC || id[1].op == issue_pkg::OP_SC
		|| id[0].is_priv || id[1].is_priv
		|| id[1].op == issue_pkg::OP_DIV || id[1].op == issue_pkg::OP_DIVU;

	assign stall_req = load_related[0]
		| (load_related[1] & ~instr2_not_taken)
		| (id[0].is_nonrw_priv & priv_executing)
		| nonrw_priv_executing
		| ~instr_valid[0];

	always_comb begin
		issue_instr = id;
		issue_num   = 2'd2;
		if (stall_req) begin
			issue_num   = 2'd0;
			issue_instr = '0;
		end else if (instr2_not_taken) begin
			issue_num      = 2'd1;
			issue_instr[1] = '0;
		end
	end

	assign stage.issue_instr = issue_instr;
	assign stage.issue_num   = issue_num;
	assign head.pop_num      = issue_num;

endmodule

`default_nettype wire

// ==== logic/pipe_tracker.sv ====
`default_nettype none

module pipe_tracker (
	input  logic                                   clk,
	input  logic                                   rst_n,
	stage_if.tracker                               stage,
	output logic [issue_pkg::ISSUE_NUM-1:0]        retire_valid,
	output logic [issue_pkg::ISSUE_NUM-1:0][31:0]  retire_pc,
	output logic [issue_pkg::ISSUE_NUM-1:0][31:0]  retire_instr
);

	localparam int N = issue_pkg::ISSUE_NUM;
	localparam int D = issue_pkg::DCACHE_PIPE_DEPTH;

	logic [N-1:0]                      issue_valid;
	logic [N-1:0]                      ex_valid;
	logic [D-1:0][N-1:0]               dc_valid;
	issue_pkg::decoded_instr_t [N-1:0] ex_q;
	issue_pkg::decoded_instr_t [D-1:0][N-1:0] dc_q;

	// slot i is live when fewer than issue_num slots precede it
	for (genvar i = 0; i < N; i++) begin : g_issue_valid
		assign issue_valid[i] = stage.issue_num > i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= '0;
			dc_valid <= '0;
		end else begin
			// issue_num of 0 shifts in a bubble
			ex_valid    <= issue_valid;
			dc_valid[0] <= ex_valid;
			for (int k = 1; k < D; k++) begin
				dc_valid[k] <= dc_valid[k-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		ex_q    <= stage.issue_instr;
		dc_q[0] <= ex_q;
		for (int k = 1; k < D; k++) begin
			dc_q[k] <= dc_q[k-1];
		end
	end

	// empty slots look like nops to the hazard checks
	for (genvar i = 0; i < N; i++) begin : g_feedback
		assign stage.ex_instr[i] = ex_valid[i] ? ex_q[i] : '0;
		for (genvar k = 0; k < D; k++) begin : g_dc
			assign stage.dcache_instr[k][i] = dc_valid[k][i] ? dc_q[k][i] : '0;
		end
	end

	assign retire_valid = dc_valid[D-1];

	for (genvar i = 0; i < N; i++) begin : g_retire
		assign retire_pc[i]    = dc_q[D-1][i].pc;
		assign retire_instr[i] = dc_q[D-1][i].instr;
	end

endmodule

`default_nettype wire

// ==== logic/issue_top.sv ====
`default_nettype none

module issue_top (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   fetch_valid,
	input  logic [31:0]                            fetch_pc,
	input  logic [31:0]                            fetch_instr,
	output logic [issue_pkg::ISSUE_CNT_W-1:0]      credit_return,
	output logic [issue_pkg::ISSUE_NUM-1:0]        retire_valid,
	output logic [issue_pkg::ISSUE_NUM-1:0][31:0]  retire_pc,
	output logic [issue_pkg::ISSUE_NUM-1:0][31:0]  retire_instr
);

	head_if  h_if ();
	stage_if s_if ();

	issue_pkg::decoded_instr_t [issue_pkg::ISSUE_NUM-1:0] dec;

	fetch_queue u_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_instr   (fetch_instr),
		.head          (h_if.queue),
		.credit_return (credit_return)
	);

	// one decoder per head entry
	for (genvar i = 0; i < issue_pkg::ISSUE_NUM; i++) begin : g_dec
		instr_decoder u_dec (
			.entry   (h_if.entry[i]),
			.decoded (dec[i])
		);
	end

	instr_issue u_issue (
		.entry0 (h_if.entry[0]),
		.entry1 (h_if.entry[1]),
		.id0    (dec[0]),
		.id1    (dec[1]),
		.stage  (s_if.issue),
		.head   (h_if.issue)
	);

	pipe_tracker u_tracker (
		.clk          (clk),
		.rst_n        (rst_n),
		.stage        (s_if.tracker),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_instr (retire_instr)
	);

endmodule

`default_nettype wire

// ==== tests/issue_tb.sv ====
`default_nettype none

module issue_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 1000;
	localparam int RANDOM_WORDS = 200;
	localparam int BURST_WORDS = 6;

	typedef struct packed {
		logic mem;
		logic hilo;
		logic solo;
		logic div;
		logic load;
		logic ctrl;
		logic eret;
	} attr_t;

	logic clk;
	logic rst_n;
	logic fetch_valid;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_instr;
	logic [issue_pkg::ISSUE_CNT_W-1:0] credit_return;
	logic [issue_pkg::ISSUE_NUM-1:0] retire_valid;
	logic [issue_pkg::ISSUE_NUM-1:0][31:0] retire_pc;
	logic [issue_pkg::ISSUE_NUM-1:0][31:0] retire_instr;

	logic [31:0] exp_pc[$];
	logic [31:0] exp_instr[$];
	int pair_cycles[$];
	int burst_single;
	int credits;
	int errors;
	int cycle;
	int last_eret;
	int last_load [32];
	int tests_run;
	int tests_failed;
	logic timed_out;
	logic [31:0] rng;

	issue_top dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_instr   (fetch_instr),
		.credit_return (credit_return),
		.retire_valid  (retire_valid),
		.retire_pc     (retire_pc),
		.retire_instr  (retire_instr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one encoding from the list, registers limited to r0..r7 for frequent hazards
	function automatic logic [31:0] gen_word(input logic [31:0] r);
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		ra = {2'b00, r[6:4]};
		rb = {2'b00, r[9:7]};
		rc = {2'b00, r[12:10]};
		case (r[3:0])
			4'd0, 4'd1, 4'd2: return {6'h00, ra, rb, rc, 5'd0, 6'h21};
			4'd3, 4'd4: return {6'h09, ra, rb, r[31:16]};
			4'd5, 4'd6: return {6'h23, ra, rb, 16'h0010};
			4'd7: return {6'h2b, ra, rb, 16'h0020};
			4'd8: return {6'h04, ra, rb, 16'h0004};
			4'd9: return {6'h00, ra, rb, 10'd0, 6'h18};
			4'd10: return {6'h00, ra, rb, 10'd0, 6'h1a};
			4'd11: return {6'h00, ra, rb, 10'd0, 6'h1b};
			4'd12: return {6'h00, 10'd0, rc, 5'd0, 6'h10};
			4'd13: return {6'h38, ra, rb, 16'h0000};
			4'd14: return 32'h0000_0040;
			default: begin
				if (r[15:14] == 2'd0) begin
					return {6'h10, 5'h00, rb, 5'd12, 11'd0};
				end else if (r[15:14] == 2'd1) begin
					return {6'h10, 5'h04, rb, 5'd12, 11'd0};
				end
				return 32'h4200_0018;
			end
		endcase
	endfunction

	function automatic attr_t attrs(input logic [31:0] w);
		attr_t a;
		a = '0;
		case (w[31:26])
			6'h00: begin
				if (w == 32'h0000_0040) begin
					a.solo = 1'b1;
				end else if (w[5:0] inside {6'h10, 6'h18, 6'h1a, 6'h1b}) begin
					a.hilo = 1'b1;
					a.div  = w[5:0] inside {6'h1a, 6'h1b};
				end
			end
			6'h23: begin
				a.mem  = 1'b1;
				a.load = 1'b1;
			end
			6'h2b: a.mem = 1'b1;
			6'h38: begin
				a.mem  = 1'b1;
				a.solo = 1'b1;
			end
			6'h04: a.ctrl = 1'b1;
			6'h10: begin
				a.solo = 1'b1;
				a.eret = w[25];
			end
			default: a = '0;
		endcase
		return a;
	endfunction

	function automatic logic [4:0] writes_reg(input logic [31:0] w);
		case (w[31:26])
			6'h00: return (w[5:0] inside {6'h18, 6'h1a, 6'h1b}) ? 5'd0 : w[15:11];
			6'h09, 6'h23, 6'h38: return w[20:16];
			6'h10: return (w[25:21] == 5'h00) ? w[20:16] : 5'd0;
			default: return 5'd0;
		endcase
	endfunction

	// two source registers packed as {first, second}
	function automatic logic [9:0] reads_reg(input logic [31:0] w);
		case (w[31:26])
			6'h00: return (w[5:0] == 6'h10) ? 10'd0 : {w[25:21], w[20:16]};
			6'h09, 6'h23: return {w[25:21], 5'd0};
			6'h2b, 6'h38, 6'h04: return {w[25:21], w[20:16]};
			6'h10: return (w[25:21] == 5'h04) ? {w[20:16], 5'd0} : 10'd0;
			default: return 10'd0;
		endcase
	endfunction

	function automatic logic pair_allowed(input logic [31:0] w0, input logic [31:0] w1);
		attr_t a0;
		attr_t a1;
		logic [4:0] wr0;
		logic [9:0] rd1;
		logic related;
		a0 = attrs(w0);
		a1 = attrs(w1);
		wr0 = writes_reg(w0);
		rd1 = reads_reg(w1);
		related = wr0 != 5'd0 && (rd1[9:5] == wr0 || rd1[4:0] == wr0);
		return !(related || (a0.mem && a1.mem) || (a0.hilo && a1.hilo)
			|| a0.solo || a1.solo || a1.div || (a0.load && a1.ctrl));
	endfunction

	// called at posedge + 1 ns, returns at the next posedge + 1 ns
	task automatic send_word(input logic [31:0] pc, input logic [31:0] w);
		int waited;
		waited = 0;
		if (timed_out) begin
			return;
		end
		while (credits == 0 && waited < WAIT_LIMIT) begin
			fetch_valid = 1'b0;
			@(posedge clk);
			#1;
			waited++;
		end
		if (credits == 0) begin
			$display("timeout: no credit came back for pc %h", pc);
			timed_out = 1'b1;
			errors++;
			return;
		end
		fetch_valid = 1'b1;
		fetch_pc    = pc;
		fetch_instr = w;
		exp_pc.push_back(pc);
		exp_instr.push_back(w);
		credits--;
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
	endtask

	task automatic wait_retired();
		int waited;
		waited = 0;
		while (exp_pc.size() != 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_pc.size() != 0) begin
			$display("timeout: %0d fetched words never retired", exp_pc.size());
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic wait_credits();
		int waited;
		waited = 0;
		while (credits != issue_pkg::QUEUE_DEPTH && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (credits != issue_pkg::QUEUE_DEPTH) begin
			$display("timeout: credit count stuck at %0d after drain", credits);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int n);
		tests_run++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n);
			tests_failed++;
		end
	endtask

	task automatic retire_one(input int s);
		logic [31:0] pc;
		logic [31:0] w;
		logic [9:0] rr;
		logic [4:0] wr;
		attr_t a;
		if (exp_pc.size() == 0) begin
			$display("slot %0d retired pc %h with nothing outstanding", s, retire_pc[s]);
			errors++;
			return;
		end
		pc = exp_pc.pop_front();
		w = exp_instr.pop_front();
		if (retire_pc[s] !== pc) begin
			$display("MISMATCH retire_pc[%0d]: got %h expected %h", s, retire_pc[s], pc);
			errors++;
		end
		if (retire_instr[s] !== w) begin
			$display("MISMATCH retire_instr[%0d]: got %h expected %h", s, retire_instr[s], w);
			errors++;
		end
		w = retire_instr[s];
		rr = reads_reg(w);
		wr = writes_reg(w);
		a = attrs(w);
		// a reader needs three cycles behind any load of its sources
		if ((rr[9:5] != 5'd0 && cycle - last_load[rr[9:5]] < 3)
			|| (rr[4:0] != 5'd0 && cycle - last_load[rr[4:0]] < 3)) begin
			$display("word %h at cycle %0d retired too close to a load it reads", w, cycle);
			errors++;
		end
		if (a.load && wr != 5'd0) begin
			last_load[wr] = cycle;
		end
		if (a.eret) begin
			if (s != 0 || retire_valid != 2'b01) begin
				$display("ERET at cycle %0d did not retire alone", cycle);
				errors++;
			end
			last_eret = cycle;
		end
	endtask

	task automatic compare_cycle();
		credits += credit_return;
		if (credits > issue_pkg::QUEUE_DEPTH) begin
			$display("credit count %0d went above the queue depth", credits);
			errors++;
		end
		if (retire_valid == 2'b10) begin
			$display("slot 1 retired without slot 0 at cycle %0d", cycle);
			errors++;
		end
		if (retire_valid != 2'b00 && cycle - last_eret <= 3) begin
			$display("retire at cycle %0d came within 3 cycles of an ERET", cycle);
			errors++;
		end
		if (retire_valid == 2'b11 && !pair_allowed(retire_instr[0], retire_instr[1])) begin
			$display("words %h and %h retired as a pair but may not pair",
				retire_instr[0], retire_instr[1]);
			errors++;
		end
		// burst words carry pcs in the 0x008xxxxx range
		if (retire_valid[0] && retire_pc[0][31:20] == 12'h008) begin
			if (retire_valid == 2'b11) begin
				pair_cycles.push_back(cycle);
			end else begin
				burst_single++;
			end
		end
		for (int s = 0; s < issue_pkg::ISSUE_NUM; s++) begin
			if (retire_valid[s]) begin
				retire_one(s);
			end
		end
	endtask

	// comparing process, samples at the falling edge
	initial begin
		cycle = 0;
		forever begin
			@(negedge clk);
			cycle++;
			if (rst_n) begin
				compare_cycle();
			end
		end
	end

	initial begin
		int phase_err;
		rst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fetch_instr = '0;
		credits = issue_pkg::QUEUE_DEPTH;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		burst_single = 0;
		last_eret = -100;
		foreach (last_load[r]) begin
			last_load[r] = -100;
		end
		rng = 32'h176c5ccf;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		// random mix, covers order, pairing, load-use and ERET rules
		phase_err = errors;
		for (int i = 0; i < RANDOM_WORDS; i++) begin
			rng = xorshift(rng);
			send_word(32'h0040_0000 + 32'(i) * 4, gen_word(rng));
			if (rng[30:29] == 2'd0 && !timed_out) begin
				@(posedge clk);
				#1;
			end
		end
		wait_retired();
		report_test("random stream", errors - phase_err);

		// ERET holds issue for 3 cycles so the queue fills behind it
		phase_err = errors;
		if (!timed_out) begin
			pair_cycles.delete();
			burst_single = 0;
			send_word(32'h0070_0000, 32'h4200_0018);
			for (int i = 0; i < BURST_WORDS; i++) begin
				send_word(32'h0080_0000 + 32'(i) * 4,
					{6'h00, 5'd0, 5'd0, 5'(8 + i), 5'd0, 6'h21});
			end
			wait_retired();
			if (burst_single != 0 || pair_cycles.size() != BURST_WORDS / 2) begin
				$display("ALU burst retired as %0d pairs and %0d singles",
					pair_cycles.size(), burst_single);
				errors++;
			end else if (pair_cycles[1] != pair_cycles[0] + 1
				|| pair_cycles[2] != pair_cycles[1] + 1) begin
				$display("ALU burst pairs did not retire on consecutive cycles");
				errors++;
			end
		end
		report_test("alu burst", errors - phase_err);

		phase_err = errors;
		if (!timed_out) begin
			wait_credits();
		end
		report_test("credit drain", errors - phase_err);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/issue_pkg.sv
logic/fetch_queue.sv
logic/instr_decoder.sv
logic/instr_issue.sv
logic/pipe_tracker.sv
logic/issue_top.sv
tests/issue_tb.sv

// ==== Bender.yml ====
package:
  name: issue_frontend

sources:
  - logic/issue_pkg.sv
  - logic/fetch_queue.sv
  - logic/instr_decoder.sv
  - logic/instr_issue.sv
  - logic/pipe_tracker.sv
  - logic/issue_top.sv
  - target: test
    files:
      - tests/issue_tb.sv
